/* src/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry
`define CACHE_WAYS        8
`define CACHE_SETS        16
`define CACHE_WAY_BITS    3
`define CACHE_SET_BITS    4
`define CACHE_OFFSET_BITS 5
`define CACHE_TAG_BITS    23
`define CACHE_LINE_BITS   256

// tuner rule
`define TUNE_WINDOW       16   // requests per window
`define TUNE_MISS_LIMIT   8    // misses that trigger a step up

`endif

/* src/cache_store_pkg.sv */
`default_nettype none
`include "cache_macros.svh"

package cache_store_pkg;

    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]    tag;
        logic [`CACHE_SET_BITS-1:0]    set;
        logic [`CACHE_OFFSET_BITS-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [`CACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

    // encoded in order of growing associativity
    typedef enum logic [1:0] {
        mode_dm   = 2'd0,
        mode_2way = 2'd1,
        mode_4way = 2'd2,
        mode_8way = 2'd3
    } assoc_mode_t;

endpackage

`default_nettype wire

/* src/cache_ctrl_pkg.sv */
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_refill,
        st_respond
    } ctrl_state_t;

    typedef enum logic [1:0] {
        op_none,
        op_read,
        op_write
    } mem_op_t;

endpackage

`default_nettype wire

/* src/cache_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

interface cache_if;

    logic                       fill_en;      // write whole refilled line
    logic                       cpu_wen;      // merge cpu store bytes
    logic                       touch;        // plru update
    logic                       hit;
    logic                       victim_dirty; // victim needs writeback
    logic [`CACHE_TAG_BITS-1:0] victim_tag;

    modport ctrl (
        output fill_en, cpu_wen, touch,
        input  hit, victim_dirty, victim_tag
    );

    modport store (
        input  fill_en, cpu_wen, touch,
        output hit, victim_dirty, victim_tag
    );

endinterface

`default_nettype wire

/* src/cache_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,       // cpu strobe
    input  logic                    is_write,
    input  logic                    mem_resp,
    cache_if.ctrl                   ctl,
    output cache_ctrl_pkg::mem_op_t mem_op,
    output logic                    resp,
    output logic                    miss
);

    cache_ctrl_pkg::ctrl_state_t state;
    cache_ctrl_pkg::ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_ctrl_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next  = state;
        mem_op      = cache_ctrl_pkg::op_none;
        ctl.fill_en = 1'b0;
        ctl.cpu_wen = 1'b0;
        ctl.touch   = 1'b0;
        resp        = 1'b0;
        miss        = 1'b0;
        case (state)
            cache_ctrl_pkg::st_idle: begin
                if (req) state_next = cache_ctrl_pkg::st_compare;
            end
            cache_ctrl_pkg::st_compare: begin
                if (ctl.hit) begin
                    ctl.touch   = 1'b1;
                    ctl.cpu_wen = is_write;   // store lands before the response
                    state_next  = cache_ctrl_pkg::st_respond;
                end else begin
                    // second compare after a fill always hits, so this fires once
                    miss       = 1'b1;
                    state_next = ctl.victim_dirty ? cache_ctrl_pkg::st_writeback
                                                  : cache_ctrl_pkg::st_refill;
                end
            end
            cache_ctrl_pkg::st_writeback: begin
                mem_op = cache_ctrl_pkg::op_write;
                if (mem_resp) state_next = cache_ctrl_pkg::st_refill;
            end
            cache_ctrl_pkg::st_refill: begin
                mem_op = cache_ctrl_pkg::op_read;
                if (mem_resp) begin
                    ctl.fill_en = 1'b1;       // dfp_rdata only valid now
                    state_next  = cache_ctrl_pkg::st_compare;
                end
            end
            cache_ctrl_pkg::st_respond: begin
                resp       = 1'b1;
                state_next = cache_ctrl_pkg::st_idle;
            end
            default: state_next = cache_ctrl_pkg::st_idle;
        endcase
    end

endmodule

`default_nettype wire

/* src/assoc_tuner.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module assoc_tuner (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        resp,
    input  logic                        miss,
    output cache_store_pkg::assoc_mode_t mode
);

    localparam int CNT_BITS  = $clog2(`TUNE_WINDOW);
    localparam int MISS_BITS = $clog2(`TUNE_WINDOW + 1);   // can count a full window

    logic [CNT_BITS-1:0]  req_cnt;
    logic [MISS_BITS-1:0] miss_cnt;
    logic                 window_end;
    logic                 step_up;

    assign window_end = resp && (req_cnt == CNT_BITS'(`TUNE_WINDOW - 1));
    assign step_up    = window_end && (miss_cnt >= MISS_BITS'(`TUNE_MISS_LIMIT));

    always_ff @(posedge clk) begin
        if (rst) begin
            req_cnt  <= '0;
            miss_cnt <= '0;
            mode     <= cache_store_pkg::mode_dm;
        end else begin
            if (resp) begin
                req_cnt <= window_end ? '0 : req_cnt + 1'b1;
            end
            if (window_end) begin
                miss_cnt <= '0;
            end else if (miss) begin
                miss_cnt <= miss_cnt + 1'b1;
            end
            if (step_up) begin
                case (mode)
                    cache_store_pkg::mode_dm:   mode <= cache_store_pkg::mode_2way;
                    cache_store_pkg::mode_2way: mode <= cache_store_pkg::mode_4way;
                    default:                    mode <= cache_store_pkg::mode_8way;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/replace_plru.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module replace_plru (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`CACHE_SET_BITS-1:0]   set,
    input  logic [`CACHE_WAY_BITS-1:0]   tag_low,
    input  cache_store_pkg::assoc_mode_t mode,
    input  logic                         touch,
    input  logic [`CACHE_WAY_BITS-1:0]   touch_way,
    output logic [`CACHE_WAY_BITS-1:0]   victim_way
);

    // node 0 is the root, 1..2 pick the pair, 3..6 pick the way
    logic [`CACHE_WAYS-2:0] tree [`CACHE_SETS];
    logic [`CACHE_WAYS-2:0] node;
    logic                   v2;
    logic                   v1;
    logic                   v0;

    assign node = tree[set];

    always_comb begin
        v2 = (mode == cache_store_pkg::mode_8way) ? node[0] : tag_low[2];
        v1 = (mode >= cache_store_pkg::mode_4way) ? node[1 + v2] : tag_low[1];
        v0 = (mode != cache_store_pkg::mode_dm) ? node[3 + {v2, v1}] : tag_low[0];
        victim_way = {v2, v1, v0};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin   // point every level away from the touched way
            tree[set][0]                    <= ~touch_way[2];
            tree[set][1 + touch_way[2]]     <= ~touch_way[1];
            tree[set][3 + touch_way[2:1]]   <= ~touch_way[0];
        end
    end

endmodule

`default_nettype wire

/* src/way_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module way_store (
    input  logic                         clk,
    input  logic                         rst,
    input  cache_store_pkg::cache_addr_t addr,
    input  logic [3:0]                   wmask,
    input  logic [31:0]                  wdata,
    input  cache_store_pkg::assoc_mode_t mode,
    input  logic [`CACHE_LINE_BITS-1:0]  fill_data,
    cache_if.store                       st,
    output logic [31:0]                  rdata,
    output logic [`CACHE_LINE_BITS-1:0]  evict_data
);

    cache_store_pkg::tag_entry_t tags  [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_LINE_BITS-1:0] lines [`CACHE_SETS][`CACHE_WAYS];

    logic [`CACHE_WAYS-1:0]      in_group;
    logic [`CACHE_WAYS-1:0]      way_hit;
    logic [`CACHE_WAY_BITS-1:0]  hit_way;
    logic [`CACHE_WAY_BITS-1:0]  victim_way;
    logic [2:0]                  word_sel;
    cache_store_pkg::tag_entry_t victim_entry;

    assign word_sel = addr.offset[4:2];

    // groups nest, so a line placed in a smaller group stays visible
    always_comb begin
        logic [`CACHE_WAY_BITS-1:0] wi;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            wi = `CACHE_WAY_BITS'(w);
            case (mode)
                cache_store_pkg::mode_dm:   in_group[w] = (wi == addr.tag[2:0]);
                cache_store_pkg::mode_2way: in_group[w] = (wi[2:1] == addr.tag[2:1]);
                cache_store_pkg::mode_4way: in_group[w] = (wi[2] == addr.tag[2]);
                default:                    in_group[w] = 1'b1;
            endcase
            way_hit[w] = in_group[w] && tags[addr.set][w].valid &&
                         (tags[addr.set][w].tag == addr.tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way_hit[w]) hit_way = `CACHE_WAY_BITS'(w);
        end
    end

    assign st.hit          = |way_hit;
    assign rdata           = lines[addr.set][hit_way][word_sel*32 +: 32];
    assign victim_entry    = tags[addr.set][victim_way];
    assign st.victim_dirty = victim_entry.valid && victim_entry.dirty;
    assign st.victim_tag   = victim_entry.tag;
    assign evict_data      = lines[addr.set][victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    tags[s][w] <= '0;
                end
            end
        end else if (st.fill_en) begin
            tags[addr.set][victim_way] <= cache_store_pkg::tag_entry_t'{
                valid: 1'b1, dirty: 1'b0, tag: addr.tag};
        end else if (st.cpu_wen) begin
            tags[addr.set][hit_way].dirty <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (st.fill_en) begin
            lines[addr.set][victim_way] <= fill_data;
        end else if (st.cpu_wen) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin   // byte merge
                    lines[addr.set][hit_way][word_sel*32 + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    replace_plru i_replace_plru (
        .clk        (clk),
        .rst        (rst),
        .set        (addr.set),
        .tag_low    (addr.tag[2:0]),
        .mode       (mode),
        .touch      (st.touch),
        .touch_way  (hit_way),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

/* src/mutative_cache.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module mutative_cache (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [31:0]                  ufp_addr,
    input  logic [3:0]                   ufp_rmask,
    input  logic [3:0]                   ufp_wmask,
    input  logic [31:0]                  ufp_wdata,
    output logic [31:0]                  ufp_rdata,
    output logic                         ufp_resp,
    output logic [31:0]                  dfp_addr,
    output logic                         dfp_read,
    output logic                         dfp_write,
    output logic [`CACHE_LINE_BITS-1:0]  dfp_wdata,
    input  logic [`CACHE_LINE_BITS-1:0]  dfp_rdata,
    input  logic                         dfp_resp,
    output cache_store_pkg::assoc_mode_t assoc_mode
);

    cache_store_pkg::cache_addr_t addr_q;
    logic [3:0]                   wmask_q;
    logic [31:0]                  wdata_q;
    logic                         req;
    logic                         miss;
    cache_ctrl_pkg::mem_op_t      mem_op;

    cache_if bus ();

    assign req = (|ufp_rmask) || (|ufp_wmask);   // one-cycle strobe

    always_ff @(posedge clk) begin
        if (req) begin
            addr_q  <= ufp_addr;
            wdata_q <= ufp_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wmask_q <= '0;
        end else if (req) begin
            wmask_q <= ufp_wmask;
        end
    end

    assign dfp_read  = (mem_op == cache_ctrl_pkg::op_read);
    assign dfp_write = (mem_op == cache_ctrl_pkg::op_write);
    assign dfp_addr  = dfp_write ?
                       {bus.victim_tag, addr_q.set, {`CACHE_OFFSET_BITS{1'b0}}} :
                       {addr_q.tag, addr_q.set, {`CACHE_OFFSET_BITS{1'b0}}};

    cache_fsm i_cache_fsm (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .is_write (|wmask_q),
        .mem_resp (dfp_resp),
        .ctl      (bus.ctrl),
        .mem_op   (mem_op),
        .resp     (ufp_resp),
        .miss     (miss)
    );

    assoc_tuner i_assoc_tuner (
        .clk  (clk),
        .rst  (rst),
        .resp (ufp_resp),
        .miss (miss),
        .mode (assoc_mode)
    );

    way_store i_way_store (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr_q),
        .wmask      (wmask_q),
        .wdata      (wdata_q),
        .mode       (assoc_mode),
        .fill_data  (dfp_rdata),
        .st         (bus.store),
        .rdata      (ufp_rdata),
        .evict_data (dfp_wdata)
    );

endmodule

`default_nettype wire

/* testbench/mutative_cache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mutative_cache_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic [3:0]                   ufp_rmask,
    input logic [3:0]                   ufp_wmask,
    input logic                         ufp_resp,
    input logic                         dfp_read,
    input logic                         dfp_write,
    input cache_store_pkg::assoc_mode_t assoc_mode
);

    logic pending;   // request in flight

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if ((|ufp_rmask) || (|ufp_wmask)) begin
            pending <= 1'b1;
        end else if (ufp_resp) begin
            pending <= 1'b0;
        end
    end

    dfp_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write are high together");

    resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |=> !ufp_resp)
        else $error("ufp_resp stayed high for more than one cycle");

    resp_after_req: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |-> pending)
        else $error("ufp_resp without an outstanding request");

    mode_monotonic: assert property (@(posedge clk) disable iff (rst)
        assoc_mode >= $past(assoc_mode))
        else $error("assoc_mode stepped down");

endmodule

bind mutative_cache mutative_cache_assertions i_mutative_cache_assertions (.*);

`default_nettype wire

/* testbench/mutative_cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module mutative_cache_tb;

    localparam int          TIMEOUT = 200;   // cycles per wait
    localparam logic [31:0] ADDR_A  = {23'h000010, 4'h0, 5'h08};
    localparam logic [31:0] ADDR_B  = {23'h000018, 4'h0, 5'h08};   // same set and way as A in dm

    logic                         clk = 1'b0;
    logic                         rst;
    logic [31:0]                  ufp_addr;
    logic [3:0]                   ufp_rmask;
    logic [3:0]                   ufp_wmask;
    logic [31:0]                  ufp_wdata;
    logic [31:0]                  ufp_rdata;
    logic                         ufp_resp;
    logic [31:0]                  dfp_addr;
    logic                         dfp_read;
    logic                         dfp_write;
    logic [`CACHE_LINE_BITS-1:0]  dfp_wdata;
    logic [`CACHE_LINE_BITS-1:0]  dfp_rdata;
    logic                         dfp_resp;
    cache_store_pkg::assoc_mode_t assoc_mode;
    cache_store_pkg::assoc_mode_t exp_mode;

    logic [`CACHE_LINE_BITS-1:0]  mem [logic [26:0]];     // memory model lines
    logic [31:0]                  shadow [logic [29:0]];  // words written by the cpu
    logic [31:0]                  wb_addr;
    int                           errors = 0;
    int                           lat;
    int unsigned                  delay;

    mutative_cache i_mutative_cache (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] init_word(input logic [31:0] a);
        return {a[31:2], 2'b00} * 32'h9E37_79B1 ^ 32'h5A5A_0F0F;   // hash of word address
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        if (shadow.exists(a[31:2])) begin
            return shadow[a[31:2]];
        end
        return init_word(a);
    endfunction

    function automatic logic [`CACHE_LINE_BITS-1:0] line_of(input logic [31:0] a);
        logic [`CACHE_LINE_BITS-1:0] line;
        if (mem.exists(a[31:5])) begin
            return mem[a[31:5]];
        end
        for (int w = 0; w < 8; w++) begin
            line[w*32 +: 32] = init_word({a[31:5], 3'(w), 2'b00});
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // memory model answering after 1 to 5 cycles
    always begin
        @(negedge clk);
        dfp_resp = 1'b0;
        if (!rst && (dfp_read || dfp_write)) begin
            delay = $urandom % 5 + 1;
            repeat (delay - 1) @(negedge clk);
            if (dfp_write) begin
                for (int w = 0; w < 8; w++) begin
                    wb_addr = {dfp_addr[31:5], 3'(w), 2'b00};
                    check_value("dfp_wdata word", dfp_wdata[w*32 +: 32], expected_word(wb_addr));
                end
                mem[dfp_addr[31:5]] = dfp_wdata;
            end else begin
                dfp_rdata = line_of(dfp_addr);
            end
            dfp_resp = 1'b1;
        end
    end

    task automatic request(input logic [31:0] addr, input logic [3:0] wmask,
                           input logic [31:0] wdata);
        int waited;
        @(negedge clk);
        ufp_addr  = addr;
        ufp_rmask = (wmask == 4'h0) ? 4'hF : 4'h0;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        @(negedge clk);
        ufp_rmask = 4'h0;
        ufp_wmask = 4'h0;
        lat       = 1;
        waited    = 0;
        while (!ufp_resp && waited < TIMEOUT) begin
            @(negedge clk);
            lat++;
            waited++;
        end
        if (!ufp_resp) begin
            $display("timeout: no ufp_resp for address %h", addr);
            $display("test failed");
            $finish;
        end
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] exp;
        exp = expected_word(addr);
        request(addr, 4'h0, 32'h0);
        check_value("ufp_rdata", ufp_rdata, exp);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] mask,
                              input logic [31:0] data);
        logic [31:0] merged;
        merged = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) merged[b*8 +: 8] = data[b*8 +: 8];
        end
        request(addr, mask, data);
        shadow[addr[31:2]] = merged;
    endtask

    task automatic check_mode();
        @(negedge clk);   // mode moves one cycle after the closing response
        check_value("assoc_mode", 32'(assoc_mode), 32'(exp_mode));
    endtask

    // hits on A first, then cold lines kept out of A's set
    task automatic run_window(input int phase, input int n_cold);
        logic [31:0] a;
        for (int i = 0; i < `TUNE_WINDOW; i++) begin
            if (i < `TUNE_WINDOW - n_cold) begin
                read_check(ADDR_A);
                check_value("hit latency", lat, 2);
            end else begin
                a = {23'(phase * 256 + i + 64), 4'(i % 15 + 1), 5'(i % 8 * 4)};
                read_check(a);
            end
        end
        if (n_cold >= `TUNE_MISS_LIMIT && exp_mode != cache_store_pkg::mode_8way) begin
            exp_mode = cache_store_pkg::assoc_mode_t'(exp_mode + 2'd1);
        end
        check_mode();
    endtask

    initial begin
        delay     = $urandom(49567);   // seeds the generator
        rst       = 1'b1;
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        dfp_rdata = '0;
        dfp_resp  = 1'b0;
        exp_mode  = cache_store_pkg::mode_dm;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("ufp_resp", 32'(ufp_resp), 0);
        check_value("dfp_read", 32'(dfp_read), 0);
        check_value("dfp_write", 32'(dfp_write), 0);
        check_mode();

        read_check(ADDR_A);                          // cold miss
        read_check(ADDR_A);
        check_value("hit latency", lat, 2);
        write_word(ADDR_A, 4'b0110, 32'hA5C3_3C5A);  // partial byte mask
        read_check(ADDR_A);
        read_check(ADDR_B);                          // evicts dirty A
        read_check(ADDR_A);                          // refetch of the written-back line
        repeat (10) read_check(ADDR_A);              // fill out the first window
        check_mode();

        run_window(2, 16);   // all cold so dm steps to 2way
        run_window(3, 0);    // only hits
        run_window(4, 15);
        run_window(5, 15);
        run_window(6, 15);   // already at 8way
        read_check(ADDR_A);

        $display("checks done: %0d errors", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/cache_store_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_if.sv
src/cache_fsm.sv
src/assoc_tuner.sv
src/replace_plru.sv
src/way_store.sv
src/mutative_cache.sv
testbench/mutative_cache_assertions.sv
testbench/mutative_cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mutative_cache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
